// File: design/lsu_pkg.sv
/* Load/store unit types and sizes */

`default_nettype none

package lsu_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 32;
    localparam int TAG_WIDTH       = 6;
    localparam int BYTES_PER_WORD  = DATA_WIDTH / 8;

    // Direct-mapped cache geometry, one word per line
    localparam int DC_INDEX_WIDTH  = 4;
    localparam int DC_LINES        = 2 ** DC_INDEX_WIDTH;
    localparam int DC_OFFSET_WIDTH = 2;
    localparam int DC_TAG_WIDTH    = ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;

    localparam int MHQ_DEPTH       = 4;
    localparam int MHQ_TAG_WIDTH   = 2;

    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } lsu_func_e;

    typedef logic [BYTES_PER_WORD-1:0] byte_select_t;

    // One cache word, seen whole or byte by byte
    typedef union packed {
        logic [DATA_WIDTH-1:0]               word;
        logic [BYTES_PER_WORD-1:0][7:0]      bytes;
    } dc_word_u;

    // Operation as it arrives at the issue port
    typedef struct packed {
        lsu_func_e                func;
        logic [ADDR_WIDTH-1:0]    base;
        logic [ADDR_WIDTH-1:0]    offset;
        logic [DATA_WIDTH-1:0]    data;
        logic [TAG_WIDTH-1:0]     tag;
        logic                     retire;
    } lsu_issue_t;

    // Operation after address generation
    typedef struct packed {
        lsu_func_e                func;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [DATA_WIDTH-1:0]    data;
        logic [TAG_WIDTH-1:0]     tag;
        logic                     retire;
    } lsu_op_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [TAG_WIDTH-1:0]     tag;
    } wb_result_t;

    // MHQ entry, also the request shown to memory
    typedef struct packed {
        logic                     we;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [DATA_WIDTH-1:0]    data;
        byte_select_t             byte_select;
    } mhq_req_t;

    typedef struct packed {
        logic                     en;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [DATA_WIDTH-1:0]    data;
        byte_select_t             byte_select;
    } dc_write_t;

endpackage

`default_nettype wire

// File: design/lsu_agu.sv
/* LSU address generation */

`timescale 1ns/10ps
`default_nettype none

module lsu_agu (
    input  logic                i_clk,
    input  logic                i_reset,

    // Issue port
    input  logic                i_valid,
    input  lsu_pkg::lsu_issue_t i_op,

    // To execute stage
    output logic                o_valid,
    output lsu_pkg::lsu_op_t    o_op
);

    logic [lsu_pkg::ADDR_WIDTH-1:0] eff_addr;

    assign eff_addr = i_op.base + i_op.offset;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Payload follows the strobe without reset
    always_ff @(posedge i_clk) begin
        o_op.func   <= i_op.func;
        o_op.addr   <= eff_addr;
        o_op.data   <= i_op.data;
        o_op.tag    <= i_op.tag;
        o_op.retire <= i_op.retire;
    end

endmodule

`default_nettype wire

// File: design/lsu_ex.sv
/* LSU execute stage */

`timescale 1ns/10ps
`default_nettype none

module lsu_ex (
    // From address generation
    input  logic                                i_valid,
    input  lsu_pkg::lsu_op_t                    i_op,

    // D$ lookup and store write
    input  logic                                i_dc_hit,
    input  logic                                i_dc_busy,
    input  lsu_pkg::dc_word_u                   i_dc_data,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]      o_dc_addr,
    output lsu_pkg::dc_write_t                  o_dc_write,

    // MHQ enqueue on a miss
    input  logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   i_mhq_enq_tag,
    output logic                                o_mhq_enq_en,
    output lsu_pkg::mhq_req_t                   o_mhq_enq,

    // To writeback stage
    output logic                                o_wb_valid,
    output lsu_pkg::wb_result_t                 o_wb,
    output logic                                o_lq_update_en,
    output logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   o_lq_update_mhq_tag
);

    logic                           is_store;
    logic                           dc_ready;
    logic                           cache_miss;
    lsu_pkg::byte_select_t          byte_select;
    logic [lsu_pkg::DATA_WIDTH-1:0] load_data;

    assign is_store   = i_op.func inside {lsu_pkg::LSU_FUNC_SB, lsu_pkg::LSU_FUNC_SH,
                                          lsu_pkg::LSU_FUNC_SW};
    assign dc_ready   = i_dc_hit && !i_dc_busy;
    // A busy cycle is neither hit nor miss, the op gets replayed
    assign cache_miss = i_valid && !i_dc_hit && !i_dc_busy;

    assign o_dc_addr  = i_op.addr;

    // Only retiring stores that hit touch the cache
    always_comb begin
        o_dc_write.en          = i_valid && is_store && i_op.retire && dc_ready;
        o_dc_write.addr        = i_op.addr;
        o_dc_write.data        = i_op.data;
        o_dc_write.byte_select = byte_select;
    end

    // Loads need a ready hit, stores report on their first pass
    assign o_wb_valid = i_valid && (is_store ? !i_op.retire : dc_ready);

    always_comb begin
        o_wb.data = load_data;
        o_wb.addr = i_op.addr;
        o_wb.tag  = i_op.tag;
    end

    assign o_lq_update_en      = cache_miss && !is_store;
    assign o_lq_update_mhq_tag = i_mhq_enq_tag;

    // Store misses go out only once retired
    assign o_mhq_enq_en = cache_miss && (!is_store || i_op.retire);

    always_comb begin
        o_mhq_enq.we          = is_store && i_op.retire;
        o_mhq_enq.addr        = i_op.addr;
        o_mhq_enq.data        = i_op.data;
        o_mhq_enq.byte_select = byte_select;
    end

    always_comb begin
        case (i_op.func)
            lsu_pkg::LSU_FUNC_SB: byte_select = 4'b0001;
            lsu_pkg::LSU_FUNC_SH: byte_select = 4'b0011;
            default:              byte_select = 4'b1111;
        endcase
    end

    // Sign extend LB/LH, zero extend LBU/LHU
    always_comb begin
        case (i_op.func)
            lsu_pkg::LSU_FUNC_LB:
                load_data = {{(lsu_pkg::DATA_WIDTH-8){i_dc_data.bytes[0][7]}},
                             i_dc_data.bytes[0]};
            lsu_pkg::LSU_FUNC_LH:
                load_data = {{(lsu_pkg::DATA_WIDTH-16){i_dc_data.bytes[1][7]}},
                             i_dc_data.bytes[1], i_dc_data.bytes[0]};
            lsu_pkg::LSU_FUNC_LBU:
                load_data = {{(lsu_pkg::DATA_WIDTH-8){1'b0}}, i_dc_data.bytes[0]};
            lsu_pkg::LSU_FUNC_LHU:
                load_data = {{(lsu_pkg::DATA_WIDTH-16){1'b0}},
                             i_dc_data.bytes[1], i_dc_data.bytes[0]};
            default:
                load_data = i_dc_data.word;
        endcase
    end

endmodule

`default_nettype wire

// File: design/lsu_dcache.sv
/* Direct-mapped data cache */

`timescale 1ns/10ps
`default_nettype none

module lsu_dcache (
    input  logic                            i_clk,
    input  logic                            i_reset,

    // Lookup
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]  i_addr,
    output logic                            o_hit,
    output logic                            o_busy,
    output lsu_pkg::dc_word_u               o_data,

    // Write ports
    input  lsu_pkg::dc_write_t              i_store,
    input  lsu_pkg::dc_write_t              i_fill
);

    logic [lsu_pkg::DC_LINES-1:0]       line_valid;
    logic [lsu_pkg::DC_TAG_WIDTH-1:0]   line_tag [lsu_pkg::DC_LINES];
    lsu_pkg::dc_word_u                  line_data [lsu_pkg::DC_LINES];

    logic [lsu_pkg::DC_INDEX_WIDTH-1:0] rd_index;
    logic [lsu_pkg::DC_TAG_WIDTH-1:0]   rd_tag;
    lsu_pkg::dc_write_t                 wr;
    logic [lsu_pkg::DC_INDEX_WIDTH-1:0] wr_index;
    logic [lsu_pkg::DC_TAG_WIDTH-1:0]   fill_tag;

    assign rd_index = i_addr[lsu_pkg::DC_OFFSET_WIDTH +: lsu_pkg::DC_INDEX_WIDTH];
    assign rd_tag   = i_addr[lsu_pkg::ADDR_WIDTH-1 -: lsu_pkg::DC_TAG_WIDTH];

    // Combinational read
    assign o_hit  = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
    assign o_data = line_data[rd_index];
    assign o_busy = i_fill.en;

    // Fill wins the single write port
    assign wr       = i_fill.en ? i_fill : i_store;
    assign wr_index = wr.addr[lsu_pkg::DC_OFFSET_WIDTH +: lsu_pkg::DC_INDEX_WIDTH];
    assign fill_tag = i_fill.addr[lsu_pkg::ADDR_WIDTH-1 -: lsu_pkg::DC_TAG_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            line_valid <= '0;
        end else if (i_fill.en) begin
            line_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fill.en) begin
            line_tag[wr_index] <= fill_tag;
        end
    end

    // Fills carry a full byte select, stores only their own bytes
    always_ff @(posedge i_clk) begin
        if (wr.en) begin
            for (int b = 0; b < lsu_pkg::BYTES_PER_WORD; b++) begin
                if (wr.byte_select[b]) begin
                    line_data[wr_index].bytes[b] <= wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/lsu_mhq.sv
/* Miss handling queue */

`timescale 1ns/10ps
`default_nettype none

module lsu_mhq (
    input  logic                                i_clk,
    input  logic                                i_reset,

    // Enqueue from execute stage
    input  logic                                i_enq_en,
    input  lsu_pkg::mhq_req_t                   i_enq,
    output logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   o_enq_tag,
    output logic                                o_full,

    // Memory port
    output logic                                o_mem_req_valid,
    output lsu_pkg::mhq_req_t                   o_mem_req,
    input  logic                                i_mem_fill_valid,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_mem_fill_data,

    // Fill write into the cache
    output lsu_pkg::dc_write_t                  o_fill
);

    lsu_pkg::mhq_req_t                      entries [lsu_pkg::MHQ_DEPTH];
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]      head;
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]      tail;
    logic [lsu_pkg::MHQ_TAG_WIDTH:0]        count;
    logic                                   enq;
    logic                                   deq;
    lsu_pkg::dc_word_u                      fill_word;

    assign o_full          = count == (lsu_pkg::MHQ_TAG_WIDTH+1)'(lsu_pkg::MHQ_DEPTH);
    assign o_mem_req_valid = count != '0;
    assign o_mem_req       = entries[head];
    assign o_enq_tag       = tail;

    assign enq = i_enq_en && !o_full;
    assign deq = i_mem_fill_valid && o_mem_req_valid;

    // Store bytes override the returned line
    always_comb begin
        fill_word.word = i_mem_fill_data;
        if (o_mem_req.we) begin
            for (int b = 0; b < lsu_pkg::BYTES_PER_WORD; b++) begin
                if (o_mem_req.byte_select[b]) begin
                    fill_word.bytes[b] = o_mem_req.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_fill.en          = deq;
        o_fill.addr        = o_mem_req.addr;
        o_fill.data        = fill_word.word;
        o_fill.byte_select = '1;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enq) tail <= tail + 1'b1;
            if (deq) head <= head + 1'b1;
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (enq) begin
            entries[tail] <= i_enq;
        end
    end

endmodule

`default_nettype wire

// File: design/lsu_wb.sv
/* LSU writeback register */

`timescale 1ns/10ps
`default_nettype none

module lsu_wb (
    input  logic                                i_clk,
    input  logic                                i_reset,

    input  logic                                i_wb_valid,
    input  lsu_pkg::wb_result_t                 i_wb,
    input  logic                                i_lq_update_en,
    input  logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   i_lq_update_mhq_tag,

    output logic                                o_wb_valid,
    output lsu_pkg::wb_result_t                 o_wb,
    output logic                                o_lq_update_valid,
    output logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   o_lq_update_mhq_tag
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_valid        <= 1'b0;
            o_lq_update_valid <= 1'b0;
        end else begin
            o_wb_valid        <= i_wb_valid;
            o_lq_update_valid <= i_lq_update_en;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb                <= i_wb;
        o_lq_update_mhq_tag <= i_lq_update_mhq_tag;
    end

endmodule

`default_nettype wire

// File: design/lsu_top.sv
/* Load/store unit top */

`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  logic                                i_clk,
    input  logic                                i_reset,

    // Issue
    input  logic                                i_valid,
    input  lsu_pkg::lsu_issue_t                 i_op,

    // Writeback and load queue update
    output logic                                o_wb_valid,
    output lsu_pkg::wb_result_t                 o_wb,
    output logic                                o_lq_update_valid,
    output logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   o_lq_update_mhq_tag,
    output logic                                o_mhq_full,

    // Memory port
    output logic                                o_mem_req_valid,
    output lsu_pkg::mhq_req_t                   o_mem_req,
    input  logic                                i_mem_fill_valid,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]      i_mem_fill_data
);

    logic                               agu_valid;
    lsu_pkg::lsu_op_t                   agu_op;
    logic [lsu_pkg::ADDR_WIDTH-1:0]     dc_addr;
    lsu_pkg::dc_write_t                 dc_store;
    lsu_pkg::dc_write_t                 dc_fill;
    logic                               dc_hit;
    logic                               dc_busy;
    lsu_pkg::dc_word_u                  dc_data;
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]  mhq_enq_tag;
    logic                               mhq_enq_en;
    lsu_pkg::mhq_req_t                  mhq_enq;
    logic                               ex_wb_valid;
    lsu_pkg::wb_result_t                ex_wb;
    logic                               ex_lq_update_en;
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]  ex_lq_update_mhq_tag;

    lsu_agu lsu_agu_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_op    (i_op),
        .o_valid (agu_valid),
        .o_op    (agu_op)
    );

    lsu_ex lsu_ex_inst (
        .i_valid             (agu_valid),
        .i_op                (agu_op),
        .i_dc_hit            (dc_hit),
        .i_dc_busy           (dc_busy),
        .i_dc_data           (dc_data),
        .o_dc_addr           (dc_addr),
        .o_dc_write          (dc_store),
        .i_mhq_enq_tag       (mhq_enq_tag),
        .o_mhq_enq_en        (mhq_enq_en),
        .o_mhq_enq           (mhq_enq),
        .o_wb_valid          (ex_wb_valid),
        .o_wb                (ex_wb),
        .o_lq_update_en      (ex_lq_update_en),
        .o_lq_update_mhq_tag (ex_lq_update_mhq_tag)
    );

    lsu_dcache lsu_dcache_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_addr  (dc_addr),
        .o_hit   (dc_hit),
        .o_busy  (dc_busy),
        .o_data  (dc_data),
        .i_store (dc_store),
        .i_fill  (dc_fill)
    );

    lsu_mhq lsu_mhq_inst (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_enq_en         (mhq_enq_en),
        .i_enq            (mhq_enq),
        .o_enq_tag        (mhq_enq_tag),
        .o_full           (o_mhq_full),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_fill_valid (i_mem_fill_valid),
        .i_mem_fill_data  (i_mem_fill_data),
        .o_fill           (dc_fill)
    );

    lsu_wb lsu_wb_inst (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_wb_valid          (ex_wb_valid),
        .i_wb                (ex_wb),
        .i_lq_update_en      (ex_lq_update_en),
        .i_lq_update_mhq_tag (ex_lq_update_mhq_tag),
        .o_wb_valid          (o_wb_valid),
        .o_wb                (o_wb),
        .o_lq_update_valid   (o_lq_update_valid),
        .o_lq_update_mhq_tag (o_lq_update_mhq_tag)
    );

endmodule

`default_nettype wire

// File: verification/lsu_clkgen.sv
/* Testbench clock and reset */

`timescale 1ns/10ps
`default_nettype none

module lsu_clkgen (
    output logic o_clk,
    output logic o_reset
);

    // 20 ns period
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (10) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/lsu_assertions.sv
/* LSU interface assertions */

`timescale 1ns/10ps
`default_nettype none

module lsu_assertions (
    input wire logic              i_clk,
    input wire logic              i_reset,
    input wire logic              o_wb_valid,
    input wire logic              o_lq_update_valid,
    input wire logic              o_mem_req_valid,
    input wire lsu_pkg::mhq_req_t o_mem_req,
    input wire logic              i_mem_fill_valid
);

    // One op gives either a writeback or a load queue update
    wb_or_lq: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_wb_valid && o_lq_update_valid))
        else $error("writeback and load queue update in the same cycle");

    // Head request holds until its fill arrives
    req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_mem_req_valid && !i_mem_fill_valid |=> $stable(o_mem_req))
        else $error("memory request changed before its fill");

    fill_has_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_mem_fill_valid |-> o_mem_req_valid)
        else $error("fill arrived with no request pending");

    // Outputs quiet right after reset
    reset_clears: assert property (@(posedge i_clk)
        i_reset |=> !o_wb_valid && !o_lq_update_valid && !o_mem_req_valid)
        else $error("outputs not cleared by reset");

endmodule

bind lsu_top lsu_assertions lsu_assertions_inst (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .o_wb_valid        (o_wb_valid),
    .o_lq_update_valid (o_lq_update_valid),
    .o_mem_req_valid   (o_mem_req_valid),
    .o_mem_req         (o_mem_req),
    .i_mem_fill_valid  (i_mem_fill_valid)
);

`default_nettype wire

// File: verification/lsu_tb.sv
/* LSU random testbench */

`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    localparam int NUM_OPS = 2000;
    localparam int MEM_WORDS = 32;

    logic                                clk;
    logic                                rst;
    logic                                issue_valid;
    lsu_pkg::lsu_issue_t                 issue_op;
    logic                                fill_valid;
    logic [lsu_pkg::DATA_WIDTH-1:0]      fill_data;
    logic                                o_wb_valid;
    lsu_pkg::wb_result_t                 o_wb;
    logic                                o_lq_update_valid;
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   o_lq_update_mhq_tag;
    logic                                o_mhq_full;
    logic                                o_mem_req_valid;
    lsu_pkg::mhq_req_t                   o_mem_req;

    // Model state
    logic [lsu_pkg::DATA_WIDTH-1:0]      mem [MEM_WORDS];
    logic [lsu_pkg::DC_LINES-1:0]        m_valid;
    logic [lsu_pkg::DC_TAG_WIDTH-1:0]    m_tag [lsu_pkg::DC_LINES];
    lsu_pkg::dc_word_u                   m_data [lsu_pkg::DC_LINES];
    lsu_pkg::mhq_req_t                   m_q [lsu_pkg::MHQ_DEPTH];
    int                                  m_head;
    int                                  m_tail;
    int                                  m_count;
    logic                                m_ex_valid;
    lsu_pkg::lsu_op_t                    m_ex;

    // Expected outputs, two edges after issue
    logic                                exp_wb_valid;
    lsu_pkg::wb_result_t                 exp_wb;
    logic                                exp_wb_data_chk;
    logic                                exp_lq_valid;
    logic [lsu_pkg::MHQ_TAG_WIDTH-1:0]   exp_lq_tag;

    int                                  issued;
    int                                  error_count;
    logic                                resp_wait;
    int                                  resp_delay;

    // Scratch for the model block
    logic [lsu_pkg::DC_INDEX_WIDTH-1:0]  idx;
    logic                                hit;
    logic                                busy;
    logic                                is_store;
    lsu_pkg::byte_select_t               store_sel;
    lsu_pkg::mhq_req_t                   head_req;
    lsu_pkg::dc_word_u                   merged;
    logic [lsu_pkg::ADDR_WIDTH-1:0]      target;
    logic [lsu_pkg::ADDR_WIDTH-1:0]      issue_base;

    lsu_clkgen lsu_clkgen_inst (
        .o_clk   (clk),
        .o_reset (rst)
    );

    lsu_top lsu_top_inst (
        .i_clk               (clk),
        .i_reset             (rst),
        .i_valid             (issue_valid),
        .i_op                (issue_op),
        .o_wb_valid          (o_wb_valid),
        .o_wb                (o_wb),
        .o_lq_update_valid   (o_lq_update_valid),
        .o_lq_update_mhq_tag (o_lq_update_mhq_tag),
        .o_mhq_full          (o_mhq_full),
        .o_mem_req_valid     (o_mem_req_valid),
        .o_mem_req           (o_mem_req),
        .i_mem_fill_valid    (fill_valid),
        .i_mem_fill_data     (fill_data)
    );

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // LB/LH sign extend, LBU/LHU zero extend, LW whole word
    function automatic logic [31:0] extend_load(input lsu_pkg::lsu_func_e f,
                                                input logic [31:0] w);
        case (f)
            lsu_pkg::LSU_FUNC_LB:  return {{24{w[7]}}, w[7:0]};
            lsu_pkg::LSU_FUNC_LH:  return {{16{w[15]}}, w[15:0]};
            lsu_pkg::LSU_FUNC_LBU: return {24'h0, w[7:0]};
            lsu_pkg::LSU_FUNC_LHU: return {16'h0, w[15:0]};
            default:               return w;
        endcase
    endfunction

    function automatic lsu_pkg::byte_select_t select_for(input lsu_pkg::lsu_func_e f);
        if (f == lsu_pkg::LSU_FUNC_SB) return 4'b0001;
        if (f == lsu_pkg::LSU_FUNC_SH) return 4'b0011;
        return 4'b1111;
    endfunction

    task automatic check_wb(input logic v, input lsu_pkg::wb_result_t exp, input logic chk);
        if (o_wb_valid !== v)
            fail_run($sformatf("Error: o_wb_valid expected %h, got %h", v, o_wb_valid));
        if (v && (o_wb.addr !== exp.addr || o_wb.tag !== exp.tag))
            fail_run($sformatf("Error: o_wb expected %h, got %h", exp, o_wb));
        if (v && chk && o_wb.data !== exp.data)
            fail_run($sformatf("Error: o_wb.data expected %h, got %h", exp.data, o_wb.data));
    endtask

    task automatic check_lq(input logic v, input logic [lsu_pkg::MHQ_TAG_WIDTH-1:0] tag);
        if (o_lq_update_valid !== v)
            fail_run($sformatf("Error: o_lq_update_valid expected %h, got %h",
                               v, o_lq_update_valid));
        if (v && o_lq_update_mhq_tag !== tag)
            fail_run($sformatf("Error: o_lq_update_mhq_tag expected %h, got %h",
                               tag, o_lq_update_mhq_tag));
    endtask

    task automatic check_req(input logic v, input lsu_pkg::mhq_req_t exp);
        if (o_mem_req_valid !== v)
            fail_run($sformatf("Error: o_mem_req_valid expected %h, got %h",
                               v, o_mem_req_valid));
        if (v && (o_mem_req.we !== exp.we || o_mem_req.addr !== exp.addr))
            fail_run($sformatf("Error: o_mem_req expected %h, got %h", exp, o_mem_req));
        if (v && exp.we && o_mem_req !== exp)
            fail_run($sformatf("Error: o_mem_req expected %h, got %h", exp, o_mem_req));
    endtask

    task automatic check_full(input logic exp);
        if (o_mhq_full !== exp)
            fail_run($sformatf("Error: o_mhq_full expected %h, got %h", exp, o_mhq_full));
    endtask

    initial begin
        issue_valid = 1'b0;
        issue_op    = '0;
        fill_valid  = 1'b0;
        fill_data   = '0;
        issued      = 0;
        error_count = 0;
        void'($urandom(32'hb0dd8ad4));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) * 32'h9e3779b1) ^ {8'(i), 8'hc3, 8'(~i), 8'h5a};
        end
    end

    // Model, responder and issuer, in that order at each edge
    always @(posedge clk) begin
        if (rst) begin
            m_valid = '0;
            m_head = 0;
            m_tail = 0;
            m_count = 0;
            m_ex_valid = 1'b0;
            exp_wb_valid = 1'b0;
            exp_lq_valid = 1'b0;
            resp_wait = 1'b0;
        end else begin
            idx  = m_ex.addr[lsu_pkg::DC_OFFSET_WIDTH +: lsu_pkg::DC_INDEX_WIDTH];
            hit  = m_valid[idx] && m_tag[idx] == m_ex.addr[31 -: lsu_pkg::DC_TAG_WIDTH];
            busy = fill_valid && m_count > 0;
            is_store = m_ex.func inside {lsu_pkg::LSU_FUNC_SB, lsu_pkg::LSU_FUNC_SH,
                                         lsu_pkg::LSU_FUNC_SW};
            exp_wb_valid = 1'b0;
            exp_lq_valid = 1'b0;
            exp_wb = '{data: '0, addr: m_ex.addr, tag: m_ex.tag};
            exp_wb_data_chk = 1'b0;
            head_req = m_q[m_head];
            if (m_ex_valid && !busy) begin
                if (is_store && !m_ex.retire) begin
                    exp_wb_valid = 1'b1;
                end else if (is_store && hit) begin
                    store_sel = select_for(m_ex.func);
                    for (int b = 0; b < 4; b++)
                        if (store_sel[b])
                            m_data[idx].bytes[b] = m_ex.data[8*b +: 8];
                end else if (!is_store && hit) begin
                    exp_wb_valid = 1'b1;
                    exp_wb_data_chk = 1'b1;
                    exp_wb.data = extend_load(m_ex.func, m_data[idx].word);
                end else begin
                    exp_lq_valid = !is_store;
                    exp_lq_tag = m_tail[lsu_pkg::MHQ_TAG_WIDTH-1:0];
                    if (m_count < lsu_pkg::MHQ_DEPTH) begin
                        m_q[m_tail] = '{we: is_store, addr: m_ex.addr, data: m_ex.data,
                                        byte_select: select_for(m_ex.func)};
                        m_tail = (m_tail + 1) % lsu_pkg::MHQ_DEPTH;
                        m_count++;
                    end
                end
            end
            // Fill pops the head and allocates the merged line
            if (busy) begin
                merged.word = fill_data;
                for (int b = 0; b < 4; b++)
                    if (head_req.we && head_req.byte_select[b])
                        merged.bytes[b] = head_req.data[8*b +: 8];
                idx = head_req.addr[lsu_pkg::DC_OFFSET_WIDTH +: lsu_pkg::DC_INDEX_WIDTH];
                m_valid[idx] = 1'b1;
                m_tag[idx] = head_req.addr[31 -: lsu_pkg::DC_TAG_WIDTH];
                m_data[idx] = merged;
                m_head = (m_head + 1) % lsu_pkg::MHQ_DEPTH;
                m_count--;
            end
            m_ex_valid = issue_valid;
            m_ex = '{func: issue_op.func, addr: issue_op.base + issue_op.offset,
                     data: issue_op.data, tag: issue_op.tag, retire: issue_op.retire};

            // Memory responder, 1 to 8 cycles per request
            if (fill_valid) begin
                fill_valid <= 1'b0;
            end else if (!resp_wait && m_count > 0) begin
                resp_wait = 1'b1;
                resp_delay = 1 + $urandom % 8;
            end else if (resp_wait) begin
                resp_delay--;
                if (resp_delay == 0) begin
                    head_req = m_q[m_head];
                    fill_valid <= 1'b1;
                    fill_data  <= mem[head_req.addr[6:2]];
                    for (int b = 0; b < 4; b++)
                        if (head_req.we && head_req.byte_select[b])
                            mem[head_req.addr[6:2]][8*b +: 8] = head_req.data[8*b +: 8];
                    resp_wait = 1'b0;
                end
            end

            // Hold issue near a full MHQ or ahead of a fill
            if (issued < NUM_OPS && !o_mhq_full && m_count < 3
                && !(resp_wait && resp_delay == 1)) begin
                target     = ($urandom % MEM_WORDS) * 4;
                issue_base = $urandom & 32'hffff_fffc;
                issue_valid     <= 1'b1;
                issue_op.func   <= lsu_pkg::lsu_func_e'($urandom % 8);
                issue_op.base   <= issue_base;
                issue_op.offset <= target - issue_base;
                issue_op.data   <= $urandom;
                issue_op.tag    <= 6'($urandom);
                issue_op.retire <= 1'($urandom);
                issued++;
            end else begin
                issue_valid <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            check_wb(exp_wb_valid, exp_wb, exp_wb_data_chk);
            check_lq(exp_lq_valid, exp_lq_tag);
            check_req(m_count != 0, m_q[m_head]);
            check_full(m_count == lsu_pkg::MHQ_DEPTH);
        end
    end

    initial begin
        repeat (NUM_OPS * 40 + 1000) @(posedge clk);
        fail_run("Watchdog timeout, the run did not drain in time");
    end

    initial begin
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        while (issued < NUM_OPS) @(posedge clk);
        repeat (4) @(posedge clk);
        while (m_count != 0 || resp_wait || fill_valid) @(posedge clk);
        repeat (4) @(posedge clk);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run("Checks failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: lsu_top.f
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_ex.sv
design/lsu_dcache.sv
design/lsu_mhq.sv
design/lsu_wb.sv
design/lsu_top.sv
verification/lsu_clkgen.sv
verification/lsu_assertions.sv
verification/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - design/lsu_pkg.sv
  - design/lsu_agu.sv
  - design/lsu_ex.sv
  - design/lsu_dcache.sv
  - design/lsu_mhq.sv
  - design/lsu_wb.sv
  - design/lsu_top.sv
  - target: simulation
    files:
      - verification/lsu_clkgen.sv
      - verification/lsu_assertions.sv
      - verification/lsu_tb.sv
